// ==== hdl/tensor_core.sv ====
`timescale 1ns/100ps

module tensor_core import tensor_pkg::*; #(
    parameter int NUM_WARPS    = num_warps,
    parameter int DOT_LATENCY  = 3,
    parameter int RESULT_DEPTH = 2,
    parameter int META_DEPTH   = 6
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      exec_valid,
    input  exec_req_t exec_req,
    output logic      exec_ready,
    output logic      commit_valid,
    output commit_t   commit,
    input  logic      commit_ready
);
    // octet to dot unit
    logic     dot_valid;
    logic     dot_ready;
    dot_req_t dot_req;
    // dot unit to result queue
    logic     dot_out_valid;
    dot_rsp_t dot_out_rsp;
    logic     result_full;
    logic     result_empty;
    logic     result_push;
    dot_rsp_t result_head;
    // writeback side
    logic     rsp_pop;
    logic     meta_push;
    meta_t    meta;
    logic     meta_full;

    tensor_octet #(
        .NUM_WARPS (NUM_WARPS)
    ) i_octet (
        .clk        (clk),
        .reset      (reset),
        .exec_valid (exec_valid),
        .exec_req   (exec_req),
        .exec_ready (exec_ready),
        .dot_valid  (dot_valid),
        .dot_req    (dot_req),
        .dot_ready  (dot_ready),
        .meta_push  (meta_push),
        .meta       (meta),
        .meta_full  (meta_full)
    );

    // whole pipeline holds while the result queue is full
    tensor_dot_unit #(
        .DOT_LATENCY (DOT_LATENCY)
    ) i_dot_unit (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (dot_valid),
        .in_req    (dot_req),
        .in_ready  (dot_ready),
        .out_valid (dot_out_valid),
        .out_rsp   (dot_out_rsp),
        .out_ready (!result_full)
    );

    assign result_push = dot_out_valid && !result_full;

    // D waits here until both beats have gone out
    tensor_fifo #(
        .WIDTH ($bits(dot_rsp_t)),
        .DEPTH (RESULT_DEPTH)
    ) i_result_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (result_push),
        .pop      (rsp_pop),
        .data_in  (dot_out_rsp),
        .data_out (result_head),
        .full     (result_full),
        .empty    (result_empty)
    );

    tensor_writeback #(
        .NUM_WARPS  (NUM_WARPS),
        .META_DEPTH (META_DEPTH)
    ) i_writeback (
        .clk          (clk),
        .reset        (reset),
        .meta_push    (meta_push),
        .meta         (meta),
        .meta_full    (meta_full),
        .rsp_valid    (!result_empty),
        .rsp          (result_head),
        .rsp_pop      (rsp_pop),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

// ==== hdl/tensor_dot_unit.sv ====
`timescale 1ns/100ps

module tensor_dot_unit import tensor_pkg::*; #(
    parameter int DOT_LATENCY = 3
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  dot_req_t in_req,
    output logic     in_ready,
    output logic     out_valid,
    output dot_rsp_t out_rsp,
    input  logic     out_ready
);
    // stage 1 holds the two partial products per output
    logic  prod_valid;
    tile_t prod_k0;
    tile_t prod_k1;
    tile_t prod_c;
    wid_t  prod_wid;
    // stage 2 is the sum, index 0 here, later entries only carry it
    logic [DOT_LATENCY-2:0] res_valid;
    dot_rsp_t res_q [DOT_LATENCY-1];
    logic advance;

    // all stages move together, a full result queue freezes everything
    assign advance  = out_ready;
    assign in_ready = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
            res_valid  <= '0;
        end else if (advance) begin
            prod_valid   <= in_valid;
            res_valid[0] <= prod_valid;
            for (int k = 1; k < DOT_LATENCY - 1; k++) begin
                res_valid[k] <= res_valid[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    // products wrap to 32 bits
                    prod_k0[i][j] <= in_req.a[i][0] * in_req.b[0][j];
                    prod_k1[i][j] <= in_req.a[i][1] * in_req.b[1][j];
                    res_q[0].d[i][j] <= prod_c[i][j] + prod_k0[i][j] + prod_k1[i][j];
                end
            end
            prod_c       <= in_req.c;
            prod_wid     <= in_req.wid;
            res_q[0].wid <= prod_wid;
            for (int k = 1; k < DOT_LATENCY - 1; k++) begin
                res_q[k] <= res_q[k-1];
            end
        end
    end

    assign out_valid = res_valid[DOT_LATENCY-2];
    assign out_rsp   = res_q[DOT_LATENCY-2];

endmodule

// ==== hdl/tensor_fifo.sv ====
`timescale 1ns/100ps

module tensor_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out,
    output logic             full,
    output logic             empty
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_push;
    logic             do_pop;

    // push into a full queue and pop from an empty one are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at DEPTH, which need not be a power of two
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // head entry, visible the cycle after its push
    assign data_out = mem[rd_ptr];

endmodule

// ==== hdl/tensor_octet.sv ====
`timescale 1ns/100ps

module tensor_octet import tensor_pkg::*; #(
    parameter int NUM_WARPS = num_warps
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      exec_valid,
    input  exec_req_t exec_req,
    output logic      exec_ready,
    output logic      dot_valid,
    output dot_req_t  dot_req,
    input  logic      dot_ready,
    output logic      meta_push,
    output meta_t     meta,
    input  logic      meta_full
);
    typedef word_t [3:0] half_t;

    // halves of the current substep
    half_t  a_half;
    half_t  b_half;
    // per-warp staging of the first substep
    half_t  a_buf [NUM_WARPS];
    half_t  b_buf [NUM_WARPS];
    lanes_t c_buf [NUM_WARPS];
    logic [NUM_WARPS-1:0] staged_q;
    // staged halves of the current warp, zero if nothing was staged
    half_t  a_prev;
    half_t  b_prev;
    lanes_t c_prev;
    logic   accept;
    logic   first_fire;
    logic   last_fire;

    // metadata and dot unit must both be able to take the substep
    assign exec_ready = !meta_full && (!exec_req.last_in_pair || dot_ready);
    assign accept     = exec_valid && exec_ready;
    assign first_fire = accept && !exec_req.last_in_pair;
    assign last_fire  = accept && exec_req.last_in_pair;

    // every accepted substep leaves a metadata entry
    assign meta_push = accept;
    assign meta.wid  = exec_req.wid;
    assign meta.rd   = exec_req.rd;

    // A takes one column of the 4x2 tile, B takes one row of the 2x4 tile
    always_comb begin
        a_half = {exec_req.a[5], exec_req.a[4], exec_req.a[1], exec_req.a[0]};
        b_half = exec_req.b[3:0];
        case (exec_req.step)
            STEP_HI_LO: begin
                a_half = {exec_req.a[7], exec_req.a[6], exec_req.a[3], exec_req.a[2]};
            end
            STEP_LO_HI: begin
                b_half = exec_req.b[7:4];
            end
            STEP_HI_HI: begin
                a_half = {exec_req.a[7], exec_req.a[6], exec_req.a[3], exec_req.a[2]};
                b_half = exec_req.b[7:4];
            end
            default: begin
            end
        endcase
    end

    // staged flag per warp, set by the first substep and cleared by the second
    always_ff @(posedge clk) begin
        if (reset) begin
            staged_q <= '0;
        end else if (first_fire) begin
            staged_q[exec_req.wid] <= 1'b1;
        end else if (last_fire) begin
            staged_q[exec_req.wid] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (first_fire) begin
            a_buf[exec_req.wid] <= a_half;
            b_buf[exec_req.wid] <= b_half;
            // C is kept whole, the jagged mapping is done at assembly
            c_buf[exec_req.wid] <= exec_req.c;
        end
    end

    assign a_prev = staged_q[exec_req.wid] ? a_buf[exec_req.wid] : '0;
    assign b_prev = staged_q[exec_req.wid] ? b_buf[exec_req.wid] : '0;
    assign c_prev = staged_q[exec_req.wid] ? c_buf[exec_req.wid] : '0;

    // only the second substep of a pair goes to the dot unit
    assign dot_valid = exec_valid && exec_req.last_in_pair && !meta_full;

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            // k=0 from the staged substep, k=1 from the current one
            dot_req.a[r][0] = a_prev[r];
            dot_req.a[r][1] = a_half[r];
        end
        dot_req.b[0] = b_prev;
        dot_req.b[1] = b_half;
        // each lane holds a 1x2 block of C, base lanes are 0, 1, 4 and 5
        for (int r = 0; r < 4; r++) begin
            for (int j = 0; j < 2; j++) begin
                dot_req.c[r][2*j]   = c_prev[(r % 2) + 4*(r / 2) + 2*j];
                dot_req.c[r][2*j+1] = exec_req.c[(r % 2) + 4*(r / 2) + 2*j];
            end
        end
        dot_req.wid = exec_req.wid;
    end

endmodule

// ==== hdl/tensor_pkg.sv ====
package tensor_pkg;

    // lanes in one octet, two threadgroups of four
    localparam int num_lanes = 8;
    // default warp count, wid_t is sized for this maximum
    localparam int num_warps = 4;

    typedef logic [31:0] word_t;
    typedef logic [1:0]  wid_t;
    typedef logic [4:0]  rd_t;

    // one word per lane
    typedef word_t [num_lanes-1:0] lanes_t;
    // row-major 4x4, indexed [row][col]
    typedef word_t [3:0][3:0] tile_t;
    // A tile is 4x2 (m by k)
    typedef word_t [3:0][1:0] a_tile_t;
    // B tile is 2x4 (k by n)
    typedef word_t [1:0][3:0] b_tile_t;

    // step code selects the A and B halves of a substep
    // bit 0 picks the A lane group, bit 1 the B lane group
    typedef enum logic [1:0] {
        STEP_LO_LO = 2'd0,
        STEP_HI_LO = 2'd1,
        STEP_LO_HI = 2'd2,
        STEP_HI_HI = 2'd3
    } step_t;

    // D goes back over two beats of 8 lanes each
    typedef enum logic {
        BEAT_EVEN = 1'b0,
        BEAT_ODD  = 1'b1
    } beat_t;

    // one substep from the issue side
    typedef struct packed {
        wid_t   wid;
        rd_t    rd;
        step_t  step;
        logic   last_in_pair;
        lanes_t a;
        lanes_t b;
        lanes_t c;
    } exec_req_t;

    // one writeback beat
    typedef struct packed {
        wid_t   wid;
        rd_t    rd;
        lanes_t data;
    } commit_t;

    // destination info kept per accepted substep
    typedef struct packed {
        wid_t wid;
        rd_t  rd;
    } meta_t;

    // assembled tiles for the dot unit
    typedef struct packed {
        a_tile_t a;
        b_tile_t b;
        tile_t   c;
        wid_t    wid;
    } dot_req_t;

    typedef struct packed {
        tile_t d;
        wid_t  wid;
    } dot_rsp_t;

endpackage

// ==== hdl/tensor_writeback.sv ====
`timescale 1ns/100ps

module tensor_writeback import tensor_pkg::*; #(
    parameter int NUM_WARPS  = num_warps,
    parameter int META_DEPTH = 6
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     meta_push,
    input  meta_t    meta,
    output logic     meta_full,
    input  logic     rsp_valid,
    input  dot_rsp_t rsp,
    output logic     rsp_pop,
    output logic     commit_valid,
    output commit_t  commit,
    input  logic     commit_ready
);
    logic [NUM_WARPS-1:0] meta_fulls;
    logic [NUM_WARPS-1:0] meta_empties;
    meta_t  meta_heads [NUM_WARPS];
    meta_t  head;
    beat_t  beat_q;
    logic   fire;
    // column of D for lanes 0,1 of each threadgroup, +2 for lanes 2,3
    logic [1:0] col_lo;
    lanes_t lanes;

    // queues are per warp so a warp's two beats always find their own entries
    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_meta
        tensor_fifo #(
            .WIDTH ($bits(meta_t)),
            .DEPTH (META_DEPTH)
        ) i_meta_fifo (
            .clk      (clk),
            .reset    (reset),
            .push     (meta_push && (meta.wid == wid_t'(w))),
            .pop      (fire && (rsp.wid == wid_t'(w))),
            .data_in  (meta),
            .data_out (meta_heads[w]),
            .full     (meta_fulls[w]),
            .empty    (meta_empties[w])
        );
    end

    // any full warp queue stops the issue side
    assign meta_full = |meta_fulls;

    assign head = meta_heads[rsp.wid];

    // metadata is always pushed well ahead of its result
    assign commit_valid = rsp_valid && !meta_empties[rsp.wid];
    assign fire         = commit_valid && commit_ready;

    // D leaves the queue only after the odd beat
    assign rsp_pop = fire && (beat_q == BEAT_ODD);

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_q <= BEAT_EVEN;
        end else if (fire) begin
            beat_q <= (beat_q == BEAT_EVEN) ? BEAT_ODD : BEAT_EVEN;
        end
    end

    assign col_lo = {1'b0, beat_q == BEAT_ODD};

    // jagged 1x2 mapping, threadgroup g owns rows 2g and 2g+1
    always_comb begin
        for (int g = 0; g < num_lanes / 4; g++) begin
            lanes[4*g]   = rsp.d[2*g][col_lo];
            lanes[4*g+1] = rsp.d[2*g+1][col_lo];
            lanes[4*g+2] = rsp.d[2*g][col_lo + 2'd2];
            lanes[4*g+3] = rsp.d[2*g+1][col_lo + 2'd2];
        end
    end

    assign commit.wid  = head.wid;
    assign commit.rd   = head.rd;
    assign commit.data = lanes;

endmodule

// ==== include/tb_tensor_model.svh ====
`ifndef TB_TENSOR_MODEL_SVH
`define TB_TENSOR_MODEL_SVH

// four words taken out of a lane vector
typedef word_t [3:0] quad_t;

// first substep of each warp, held until its partner arrives
exec_req_t first_sub [num_warps];
// beats still owed by the DUT, oldest first
commit_t expected_q [$];

// A half: two lanes from each threadgroup, upper pair for the HI steps
function automatic quad_t pick_a(input lanes_t a, input step_t step);
    quad_t q;
    int    offs;
    offs = (step == STEP_HI_LO || step == STEP_HI_HI) ? 2 : 0;
    for (int r = 0; r < 4; r++) begin
        q[r] = a[4 * (r / 2) + offs + (r % 2)];
    end
    return q;
endfunction

// B half: lanes 0..3 or lanes 4..7
function automatic quad_t pick_b(input lanes_t b, input step_t step);
    quad_t q;
    int    offs;
    offs = (step == STEP_LO_HI || step == STEP_HI_HI) ? 4 : 0;
    for (int j = 0; j < 4; j++) begin
        q[j] = b[offs + j];
    end
    return q;
endfunction

// D = C + A*B over k = 0 (first substep) and k = 1 (second substep)
function automatic tile_t expected_d(input exec_req_t first, input exec_req_t second);
    quad_t a0;
    quad_t a1;
    quad_t b0;
    quad_t b1;
    tile_t d;
    word_t c;
    int    base;
    a0 = pick_a(first.a, first.step);
    a1 = pick_a(second.a, second.step);
    b0 = pick_b(first.b, first.step);
    b1 = pick_b(second.b, second.step);
    for (int i = 0; i < 4; i++) begin
        // row base lanes 0, 1, 4, 5
        base = (i < 2) ? i : i + 2;
        for (int j = 0; j < 4; j++) begin
            // even columns from the first substep, odd ones from the second
            c = (j % 2 == 0) ? first.c[base + 2 * (j / 2)] : second.c[base + 2 * (j / 2)];
            d[i][j] = c + a0[i] * b0[j] + a1[i] * b1[j];
        end
    end
    return d;
endfunction

// split D into the even and odd beats and queue them
function automatic void queue_beats(input exec_req_t first, input exec_req_t second);
    tile_t   d;
    commit_t beat;
    int      row;
    int      col;
    d = expected_d(first, second);
    for (int o = 0; o < 2; o++) begin
        beat.wid = second.wid;
        // even beat pairs with the first rd, odd beat with the second
        beat.rd  = (o == 0) ? first.rd : second.rd;
        for (int l = 0; l < 8; l++) begin
            row = (l % 2) + 2 * (l / 4);
            col = 2 * ((l / 2) % 2) + o;
            beat.data[l] = d[row][col];
        end
        expected_q.push_back(beat);
    end
endfunction

// model side of an accepted substep
function automatic void record_accept(input exec_req_t req);
    if (!req.last_in_pair) begin
        first_sub[req.wid] = req;
    end else begin
        queue_beats(first_sub[req.wid], req);
    end
endfunction

`endif

// ==== sim/tb_tensor_core.sv ====
`timescale 1ns/100ps

module tb_tensor_core import tensor_pkg::*; ();
    // matches the default of the core
    localparam int dot_latency = 3;

    logic      clk;
    logic      reset;
    logic      exec_valid;
    exec_req_t exec_req;
    logic      exec_ready;
    logic      commit_valid;
    commit_t   commit;
    logic      commit_ready;

    string   test_name;
    int      errors;
    int      checks;
    int      cycle;
    int      beats_seen;
    int      even_cycle;
    int      odd_cycle;
    int      accept_cycle;
    int      step_count [4];
    bit      phase2;
    bit      pending [num_warps];
    step_t   pend_step [num_warps];
    // set once any wait runs out of time, later steps are skipped
    bit      timed_out;
    // commit held from the previous edge while not taken
    bit      stalled;
    commit_t held;
    commit_t exp_beat;

    `include "tb_tensor_model.svh"

    tensor_core i_dut (
        .clk          (clk),
        .reset        (reset),
        .exec_valid   (exec_valid),
        .exec_req     (exec_req),
        .exec_ready   (exec_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

    always #2 clk = ~clk;

    task automatic end_run();
        $display("summary: %0d checks, %0d errors, %0d beats", checks, errors, beats_seen);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // drive one substep and hold it until the core takes it
    task automatic send_substep(input wid_t wid, input logic last, input step_t step);
        exec_req_t req;
        int        waited;
        if (!timed_out) begin
            req.wid          = wid;
            req.rd           = rd_t'($urandom());
            req.step         = step;
            req.last_in_pair = last;
            for (int l = 0; l < 8; l++) begin
                req.a[l] = $urandom();
                req.b[l] = $urandom();
                req.c[l] = $urandom();
            end
            exec_valid <= 1'b1;
            exec_req   <= req;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!exec_ready && waited < 200);
            if (!exec_ready) begin
                errors++;
                timed_out = 1'b1;
                $display("[%s] timeout: substep of warp %0d not accepted in 200 cycles",
                         test_name, wid);
            end else begin
                record_accept(req);
                step_count[int'(step)]++;
                if (last) begin
                    accept_cycle = cycle;
                end
            end
        end
    endtask

    // random warps where each warp alternates first and second substeps
    task automatic run_random(input int count);
        int w;
        for (int n = 0; n < count && !timed_out; n++) begin
            w = $urandom_range(num_warps - 1);
            if (pending[w]) begin
                send_substep(wid_t'(w), 1'b1, pend_step[w]);
                pending[w] = 1'b0;
            end else begin
                pend_step[w] = step_t'($urandom_range(3));
                send_substep(wid_t'(w), 1'b0, pend_step[w]);
                pending[w] = 1'b1;
            end
            // occasional idle cycle on the request side
            if ($urandom_range(99) < 15) begin
                exec_valid <= 1'b0;
                @(posedge clk);
            end
        end
        // close every open pair
        for (int v = 0; v < num_warps; v++) begin
            if (pending[v]) begin
                send_substep(wid_t'(v), 1'b1, pend_step[v]);
                pending[v] = 1'b0;
            end
        end
        exec_valid <= 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (!timed_out && expected_q.size() != 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (!timed_out && expected_q.size() != 0) begin
            errors++;
            timed_out = 1'b1;
            $display("[%s] timeout: %0d beats still missing after %0d cycles",
                     test_name, expected_q.size(), limit);
        end
    endtask

    // ready pattern, stability and in-order compare on the commit side
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!reset) begin
            if (stalled) begin
                checks++;
                assert (commit_valid && commit == held) else begin
                    errors++;
                    $display("[%s] commit dropped or changed before it was taken", test_name);
                end
            end
            if (commit_valid && commit_ready) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("[%s] beat from warp %0d with nothing expected", test_name,
                             commit.wid);
                end else begin
                    exp_beat = expected_q.pop_front();
                    checks++;
                    assert (commit.wid == exp_beat.wid && commit.rd == exp_beat.rd) else begin
                        errors++;
                        $display("** Error [%s] beat %0d wid/rd: expected %0d/%0d, actual %0d/%0d",
                                 test_name, beats_seen, exp_beat.wid, exp_beat.rd,
                                 commit.wid, commit.rd);
                    end
                    assert (commit.data == exp_beat.data) else begin
                        errors++;
                        $display("** Error [%s] beat %0d data: expected %h, actual %h",
                                 test_name, beats_seen, exp_beat.data, commit.data);
                    end
                end
                if (beats_seen % 2 == 0) begin
                    even_cycle = cycle;
                end else begin
                    odd_cycle = cycle;
                end
                beats_seen++;
            end
            stalled = commit_valid && !commit_ready;
            held    = commit;
        end
        // about 30% low once back-pressure is on
        commit_ready <= reset ? 1'b0 : (phase2 ? ($urandom_range(99) >= 30) : 1'b1);
    end

    initial begin
        void'($urandom(72271));
        clk          = 1'b0;
        reset        = 1'b1;
        exec_valid   = 1'b0;
        exec_req     = '0;
        commit_ready = 1'b0;
        test_name    = "reset_state";
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        checks++;
        assert (exec_ready && !commit_valid) else begin
            errors++;
            $display("** Error [%s] exec_ready/commit_valid: expected 1/0, actual %0b/%0b",
                     test_name, exec_ready, commit_valid);
        end

        // one pair on one warp with ready held high
        test_name    = "single_instr";
        pend_step[0] = step_t'($urandom_range(3));
        send_substep(2'd1, 1'b0, pend_step[0]);
        send_substep(2'd1, 1'b1, pend_step[0]);
        exec_valid <= 1'b0;
        wait_drain(50);
        if (!timed_out) begin
            checks++;
            assert (even_cycle - accept_cycle == dot_latency + 1 && odd_cycle == even_cycle + 1)
            else begin
                errors++;
                $display("** Error [%s] beat cycles after accept: expected %0d/%0d, actual %0d/%0d",
                         test_name, dot_latency + 1, dot_latency + 2,
                         even_cycle - accept_cycle, odd_cycle - accept_cycle);
            end
        end

        // interleaved warps and random steps without back-pressure
        test_name = "step_sweep";
        run_random(120);
        wait_drain(400);

        // same traffic with commit_ready toggling
        test_name = "back_pressure";
        phase2    = 1'b1;
        run_random(400);
        wait_drain(2000);
        phase2 = 1'b0;
        if (!timed_out) begin
            repeat (8) @(posedge clk);
            checks++;
            assert (!commit_valid) else begin
                errors++;
                $display("[%s] extra beat after all results were committed", test_name);
            end
            for (int s = 0; s < 4; s++) begin
                checks++;
                assert (step_count[s] > 0) else begin
                    errors++;
                    $display("[%s] step code %0d never issued", test_name, s);
                end
            end
        end
        end_run();
    end

endmodule

// ==== tensor_core.f ====
+incdir+include
hdl/tensor_pkg.sv
hdl/tensor_fifo.sv
hdl/tensor_dot_unit.sv
hdl/tensor_octet.sv
hdl/tensor_writeback.sv
hdl/tensor_core.sv
sim/tb_tensor_core.sv
